// File: flist.f
+incdir+bench
common/rvPkg.sv
hdl/rvControl.sv
fetch/rvFetch.sv
hdl/rvRegFile.sv
hdl/rvImmExtend.sv
execute/rvExecute.sv
memory/rvMemory.sv
hdl/rvCoreTop.sv
bench/rvCoreTb.sv

// File: Makefile
# Verilator build and run for the RV32I pipeline

VERILATOR  ?= verilator
TOP        ?= rvCoreTb
RTL_TOP    ?= rvCoreTop
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/rvCoreTasks.svh
`ifndef RV_CORE_TASKS_SVH
`define RV_CORE_TASKS_SVH

//////////////////////////////
// Instruction encoders
//////////////////////////////

function automatic logic [31:0] rType(input logic [2:0] f3, input logic alt,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_REG};
endfunction

function automatic logic [31:0] iType(input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [11:0] imm,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

// Word store only
function automatic logic [31:0] sType(input logic [4:0] rs1, input logic [4:0] rs2,
                                      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] uType(input logic [6:0] opc, input logic [4:0] rd,
                                      input logic [19:0] imm);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

//////////////////////////////
// Program building and loading
//////////////////////////////

// Every instruction takes a 12 byte slot, two NOPs cover hazards and delay slots
task automatic emit(input logic [31:0] instr);
    prog.push_back(instr);
    prog.push_back(NOP);
    prog.push_back(NOP);
endtask

task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    // Round up so the signed low part lands on the value
    hi = value + 32'h800;
    emit(uType(OPC_LUI, rd, hi[31:12]));
    emit(iType(3'b000, rd, rd, value[11:0], OPC_IMM));
endtask

// Marker into a0, then the result from x11, then spin
task automatic closeProgram();
    emit(uType(OPC_LUI, 5'd10, MARKER[31:12]));
    emit(iType(3'b000, 5'd10, 5'd11, 12'd0, OPC_IMM));
    emit(jType(5'd0, 21'd0));
endtask

task automatic runProgram(input string name, input logic [31:0] expected);
    int n;
    int cycles;
    closeProgram();
    n = (prog.size() > RESET_CYCLES) ? prog.size() : RESET_CYCLES;
    @(posedge clk);
    rstN <= 1'b0;
    for (int i = 0; i < n; i++) begin
        imemAddr <= i[rvPkg::IMEM_AW-1:0];
        if (i < prog.size()) begin
            imemWe   <= 1'b1;
            imemData <= prog[i];
        end else begin
            imemWe   <= 1'b0;
            imemData <= NOP;
        end
        @(posedge clk);
    end
    imemWe <= 1'b0;
    rstN   <= 1'b1;
    prog.delete();
    cycles = 0;
    @(negedge clk);
    while (a0 !== MARKER && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (a0 !== MARKER) begin
        failCount++;
        $display("TIMEOUT %s: end marker never reached a0 in %0d cycles", name, TIMEOUT);
    end else begin
        // Copy from x11 writes back three slots after the marker
        repeat (WB_SETTLE) @(negedge clk);
        checkValue(name, expected, a0);
    end
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic regAluOps();
    int          failsAtStart;
    logic [31:0] a;
    logic [31:0] b;
    failsAtStart = failCount;
    for (int k = 0; k < 10; k++) begin
        a = $random(seed);
        b = $random(seed);
        loadConst(5'd5, a);
        loadConst(5'd6, b);
        emit(rType(opF3[k], opAlt[k], 5'd11, 5'd5, 5'd6));
        runProgram(opName[k], aluExpect(opF3[k], opAlt[k], a, b));
    end
    testDone("register ALU ops", failsAtStart);
endtask

task automatic immAluOps();
    int          failsAtStart;
    logic [31:0] a;
    logic [31:0] r;
    logic [11:0] imm;
    logic [31:0] pcAt;
    failsAtStart = failCount;
    for (int k = 0; k < 10; k++) begin
        // No SUBI in RV32I
        if (k == 1) begin
            continue;
        end
        a   = $random(seed);
        r   = $random(seed);
        imm = r[11:0];
        if (opF3[k] == 3'b001 || opF3[k] == 3'b101) begin
            imm = {1'b0, opAlt[k], 5'b0, r[4:0]};
        end
        loadConst(5'd5, a);
        emit(iType(opF3[k], 5'd11, 5'd5, imm, OPC_IMM));
        runProgram({opName[k], "I"}, aluExpect(opF3[k], opAlt[k], a, {{20{imm[11]}}, imm}));
    end
    r = $random(seed);
    emit(uType(OPC_LUI, 5'd11, r[19:0]));
    runProgram("LUI", {r[19:0], 12'h000});
    // One empty slot first so AUIPC sits at a nonzero pc
    r = $random(seed);
    emit(NOP);
    pcAt = prog.size() * 4;
    emit(uType(OPC_AUIPC, 5'd11, r[19:0]));
    runProgram("AUIPC", pcAt + {r[19:0], 12'h000});
    testDone("immediate ops", failsAtStart);
endtask

task automatic loadStoreRoundTrip();
    int          failsAtStart;
    logic [31:0] vals [4];
    logic [11:0] offs [4] = '{12'h000, 12'h014, 12'hFDC, 12'h064};
    logic [31:0] sum;
    failsAtStart = failCount;
    sum = '0;
    loadConst(5'd7, 32'h200);
    for (int k = 0; k < 4; k++) begin
        vals[k] = $random(seed);
        sum     = sum + vals[k];
        loadConst(5'd5, vals[k]);
        emit(sType(5'd7, 5'd5, offs[k]));
    end
    // Reverse order on the way back
    for (int k = 3; k >= 0; k--) begin
        emit(iType(3'b010, 5'd8, 5'd7, offs[k], OPC_LOAD));
        emit(rType(3'b000, 1'b0, 5'd11, 5'd11, 5'd8));
    end
    runProgram("LW/SW sum", sum);
    testDone("load/store round trip", failsAtStart);
endtask

task automatic branchOutcomes();
    int          failsAtStart;
    logic [2:0]  f3Tab [4] = '{3'b000, 3'b001, 3'b100, 3'b101};
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] expected;
    failsAtStart = failCount;
    a        = $random(seed);
    b        = $random(seed);
    expected = '0;
    loadConst(5'd5, a);
    loadConst(5'd6, b);
    for (int c = 0; c < 8; c++) begin
        // BEQ and BNE see equal then unequal, BLT and BGE see both orders
        if (c < 4) begin
            rs1 = 5'd5;
            rs2 = (c % 2 == 0) ? 5'd5 : 5'd6;
        end else begin
            rs1 = (c % 2 == 0) ? 5'd5 : 5'd6;
            rs2 = (c % 2 == 0) ? 5'd6 : 5'd5;
        end
        if (!branchTaken(f3Tab[c / 2], (rs1 == 5'd5) ? a : b, (rs2 == 5'd5) ? a : b)) begin
            expected = expected | (32'd1 << c);
        end
        emit(bType(f3Tab[c / 2], rs1, rs2, 13'd24));
        emit(iType(3'b000, 5'd11, 5'd11, 12'd1 << c, OPC_IMM));
    end
    runProgram("branches", expected);
    testDone("branches", failsAtStart);
endtask

task automatic jumpLinks();
    int failsAtStart;
    failsAtStart = failCount;
    // Slots 0-1 set x6, 2 JAL, 4 JALR, 7 is the marker, 3 5 6 are skipped
    loadConst(5'd6, 32'd80);
    emit(jType(5'd11, 21'd24));
    emit(iType(3'b000, 5'd11, 5'd11, 12'd1, OPC_IMM));
    emit(iType(3'b000, 5'd12, 5'd6, 12'd4, OPC_JALR));
    emit(iType(3'b000, 5'd11, 5'd11, 12'd2, OPC_IMM));
    emit(iType(3'b000, 5'd11, 5'd11, 12'd4, OPC_IMM));
    runProgram("JAL link", 32'd28);
    testDone("jumps", failsAtStart);
endtask

task automatic resetReload();
    int          failsAtStart;
    logic [31:0] v;
    logic [31:0] r;
    failsAtStart = failCount;
    v = $random(seed);
    loadConst(5'd11, v);
    runProgram("first program", v);
    @(posedge clk);
    rstN <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    checkValue("a0 after reset", 32'd0, a0);
    // AUIPC at address zero gives back just the immediate
    r = $random(seed);
    emit(uType(OPC_AUIPC, 5'd11, r[19:0]));
    runProgram("reloaded program", {r[19:0], 12'h000});
    testDone("reset and reload", failsAtStart);
endtask

`endif

// File: bench/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

    localparam int          CLK_HALF     = 20;
    localparam int          RESET_CYCLES = 8;
    localparam int          TIMEOUT      = 300;
    localparam int          WB_SETTLE    = 4;
    localparam logic [31:0] NOP          = 32'h0000_0013;
    localparam logic [31:0] MARKER       = 32'hA5A5_A000;

    // Major opcodes used by the encoders
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic                      clk;
    logic                      rstN;
    logic                      imemWe;
    logic [rvPkg::IMEM_AW-1:0] imemAddr;
    logic [31:0]               imemData;
    logic [31:0]               a0;

    logic [31:0] prog [$];
    integer      seed;
    int          passCount;
    int          failCount;

    // ALU operations by funct3 and instruction bit 30
    logic [2:0] opF3   [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
    logic       opAlt  [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    string      opName [10] = '{"ADD", "SUB", "AND", "OR", "XOR",
                                "SLT", "SLTU", "SLL", "SRL", "SRA"};

    rvCoreTop dut0 (
        .clk        (clk),
        .rstN_i     (rstN),
        .imemWe_i   (imemWe),
        .imemAddr_i (imemAddr),
        .imemData_i (imemData),
        .a0_o       (a0)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    //////////////////////////////
    // Reference rules
    //////////////////////////////

    function automatic logic [31:0] aluExpect(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, sa < sb};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                // Arithmetic shift keeps the sign
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] x,
                                         input logic [31:0] y);
        logic signed [31:0] sx;
        logic signed [31:0] sy;
        sx = x;
        sy = y;
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return sx < sy;
            default: return sx >= sy;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual === expected) begin
            passCount++;
        end else begin
            failCount++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic testDone(input string name, input int failsAtStart);
        $display("%s finished with %0d mismatches", name, failCount - failsAtStart);
    endtask

    `include "rvCoreTasks.svh"

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        seed      = 32'h2e0f_8bab;
        passCount = 0;
        failCount = 0;
        rstN      = 1'b0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        regAluOps();
        immAluOps();
        loadStoreRoundTrip();
        branchOutcomes();
        jumpLinks();
        resetReload();
        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/rvCoreTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTop (
    input  wire logic                      clk,
    input  wire logic                      rstN_i,
    input  wire logic                      imemWe_i,
    input  wire logic [rvPkg::IMEM_AW-1:0] imemAddr_i,
    input  wire logic [rvPkg::XLEN-1:0]    imemData_i,
    output logic [rvPkg::XLEN-1:0]         a0_o
);

    rvPkg::fetchDecT        fetchDec;
    rvPkg::ctrlT            ctrl;
    rvPkg::decExeT          decExe;
    rvPkg::exeMemT          exeMem;
    rvPkg::memWbT           memWb;
    logic [rvPkg::XLEN-1:0] rs1Data;
    logic [rvPkg::XLEN-1:0] rs2Data;
    logic [rvPkg::XLEN-1:0] imm;
    logic                   redirectValid;
    logic [rvPkg::XLEN-1:0] redirectPc;

    //////////////////////////////
    // Fetch
    //////////////////////////////

    rvFetch fetch0 (
        .clk             (clk),
        .rstN_i          (rstN_i),
        .imemWe_i        (imemWe_i),
        .imemAddr_i      (imemAddr_i),
        .imemData_i      (imemData_i),
        .redirectValid_i (redirectValid),
        .redirectPc_i    (redirectPc),
        .fetchDec_o      (fetchDec)
    );

    //////////////////////////////
    // Decode
    //////////////////////////////

    rvControl control0 (
        .instr_i (fetchDec.instr),
        .ctrl_o  (ctrl)
    );

    rvRegFile regFile0 (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .rs1Addr_i (fetchDec.instr[19:15]),
        .rs2Addr_i (fetchDec.instr[24:20]),
        .memWb_i   (memWb),
        .rs1Data_o (rs1Data),
        .rs2Data_o (rs2Data),
        .a0_o      (a0_o)
    );

    rvImmExtend immExtend0 (
        .instr_i  (fetchDec.instr),
        .immSel_i (ctrl.immSel),
        .imm_o    (imm)
    );

    // Decoded bundle handed to execute
    always_comb begin
        decExe.valid   = fetchDec.valid;
        decExe.ctrl    = ctrl;
        decExe.pc      = fetchDec.pc;
        decExe.rs1Data = rs1Data;
        decExe.rs2Data = rs2Data;
        decExe.imm     = imm;
        decExe.funct3  = fetchDec.instr[14:12];
        decExe.rd      = fetchDec.instr[11:7];
    end

    //////////////////////////////
    // Execute and memory
    //////////////////////////////

    rvExecute execute0 (
        .clk             (clk),
        .rstN_i          (rstN_i),
        .decExe_i        (decExe),
        .redirectValid_o (redirectValid),
        .redirectPc_o    (redirectPc),
        .exeMem_o        (exeMem)
    );

    // Writeback goes straight into the register file port
    rvMemory memory0 (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .exeMem_i (exeMem),
        .memWb_o  (memWb)
    );

endmodule

`default_nettype wire

// File: memory/rvMemory.sv
`timescale 1ns/1ps
`default_nettype none

module rvMemory (
    input  wire logic    clk,
    input  wire logic    rstN_i,
    input  rvPkg::exeMemT exeMem_i,
    output rvPkg::memWbT  memWb_o
);

    logic [rvPkg::XLEN-1:0]    dmem [rvPkg::DMEM_WORDS];
    logic [rvPkg::DMEM_AW-1:0] wordAddr;
    logic [rvPkg::XLEN-1:0]    readWord;
    logic [rvPkg::XLEN-1:0]    wbData;

    // Word addressed, byte offset dropped
    assign wordAddr = exeMem_i.aluResult[rvPkg::DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (exeMem_i.valid && exeMem_i.memWrite) begin
            dmem[wordAddr] <= exeMem_i.storeData;
        end
    end

    assign readWord = dmem[wordAddr];

    // Writeback source
    always_comb begin
        case (exeMem_i.wbSel)
            rvPkg::WB_MEM: wbData = readWord;
            rvPkg::WB_PC4: wbData = exeMem_i.pcPlus4;
            default:       wbData = exeMem_i.aluResult;
        endcase
    end

    //////////////////////////////
    // Memory/writeback register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            memWb_o <= '0;
        end else begin
            memWb_o.valid    <= exeMem_i.valid;
            memWb_o.regWrite <= exeMem_i.regWrite;
            memWb_o.rd       <= exeMem_i.rd;
            memWb_o.wbData   <= wbData;
        end
    end

    // Address is formed in execute, only word accesses exist
    assert property (@(posedge clk) disable iff (!rstN_i)
        (exeMem_i.valid && (exeMem_i.memRead || exeMem_i.memWrite))
        |-> (exeMem_i.aluResult[1:0] == 2'b00))
        else $error("rvMemory: misaligned access at %h", exeMem_i.aluResult);

endmodule

`default_nettype wire

// File: execute/rvExecute.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecute (
    input  wire logic               clk,
    input  wire logic               rstN_i,
    input  rvPkg::decExeT           decExe_i,
    output logic                    redirectValid_o,
    output logic [rvPkg::XLEN-1:0]  redirectPc_o,
    output rvPkg::exeMemT           exeMem_o
);

    rvPkg::decExeT          de;
    logic [rvPkg::XLEN-1:0] opA;
    logic [rvPkg::XLEN-1:0] opB;
    logic [4:0]             shamt;
    logic [rvPkg::XLEN-1:0] aluResult;
    logic                   branchTaken;

    //////////////////////////////
    // Decode/execute register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            de <= '0;
        end else begin
            de <= decExe_i;
        end
    end

    //////////////////////////////
    // ALU
    //////////////////////////////

    assign opA   = de.ctrl.aluSrcPc ? de.pc : de.rs1Data;
    assign opB   = de.ctrl.aluSrcImm ? de.imm : de.rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (de.ctrl.aluOp)
            rvPkg::ALU_ADD:    aluResult = opA + opB;
            rvPkg::ALU_SUB:    aluResult = opA - opB;
            rvPkg::ALU_AND:    aluResult = opA & opB;
            rvPkg::ALU_OR:     aluResult = opA | opB;
            rvPkg::ALU_XOR:    aluResult = opA ^ opB;
            rvPkg::ALU_SLT:    aluResult = {31'b0, $signed(opA) < $signed(opB)};
            rvPkg::ALU_SLTU:   aluResult = {31'b0, opA < opB};
            rvPkg::ALU_SLL:    aluResult = opA << shamt;
            rvPkg::ALU_SRL:    aluResult = opA >> shamt;
            rvPkg::ALU_SRA:    aluResult = $signed(opA) >>> shamt;
            rvPkg::ALU_PASS_B: aluResult = opB;
            default:           aluResult = '0;
        endcase
    end

    // Branch compare on the raw register values
    always_comb begin
        case (de.funct3)
            3'b000:  branchTaken = (de.rs1Data == de.rs2Data);
            3'b001:  branchTaken = (de.rs1Data != de.rs2Data);
            3'b100:  branchTaken = ($signed(de.rs1Data) < $signed(de.rs2Data));
            3'b101:  branchTaken = ($signed(de.rs1Data) >= $signed(de.rs2Data));
            default: branchTaken = 1'b0;
        endcase
    end

    // Redirect lands at the edge closing this cycle, no flush
    assign redirectValid_o = de.valid
                           && ((de.ctrl.branch && branchTaken) || de.ctrl.jal || de.ctrl.jalr);
    assign redirectPc_o    = de.ctrl.jalr ? {aluResult[rvPkg::XLEN-1:1], 1'b0}
                                          : de.pc + de.imm;

    //////////////////////////////
    // Execute/memory register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            exeMem_o <= '0;
        end else begin
            exeMem_o.valid     <= de.valid;
            exeMem_o.regWrite  <= de.ctrl.regWrite;
            exeMem_o.memWrite  <= de.ctrl.memWrite;
            exeMem_o.memRead   <= de.ctrl.memRead;
            exeMem_o.wbSel     <= de.ctrl.wbSel;
            exeMem_o.aluResult <= aluResult;
            exeMem_o.storeData <= de.rs2Data;
            exeMem_o.pcPlus4   <= de.pc + 32'd4;
            exeMem_o.rd        <= de.rd;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rvImmExtend.sv
`timescale 1ns/1ps
`default_nettype none

module rvImmExtend (
    input  wire logic [rvPkg::XLEN-1:0] instr_i,
    input  rvPkg::immSelT               immSel_i,
    output logic [rvPkg::XLEN-1:0]      imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (immSel_i)
            rvPkg::IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
            rvPkg::IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            rvPkg::IMM_B: imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                                   instr_i[11:8], 1'b0};
            // Already in the upper bits
            rvPkg::IMM_U: imm_o = {instr_i[31:12], 12'b0};
            rvPkg::IMM_J: imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                                   instr_i[30:21], 1'b0};
            default:      imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rvRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module rvRegFile (
    input  wire logic                   clk,
    input  wire logic                   rstN_i,
    input  wire logic [4:0]             rs1Addr_i,
    input  wire logic [4:0]             rs2Addr_i,
    input  rvPkg::memWbT                memWb_i,
    output logic [rvPkg::XLEN-1:0]      rs1Data_o,
    output logic [rvPkg::XLEN-1:0]      rs2Data_o,
    output logic [rvPkg::XLEN-1:0]      a0_o
);

    // x0 has no storage
    logic [rvPkg::XLEN-1:0] regs [1:31];
    logic                   wrEn;

    assign wrEn = memWb_i.valid && memWb_i.regWrite && (memWb_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[memWb_i.rd] <= memWb_i.wbData;
        end
    end

    // Write-through read lets writeback and decode share a cycle
    function automatic logic [rvPkg::XLEN-1:0] readReg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wrEn && (addr == memWb_i.rd)) begin
            return memWb_i.wbData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data_o = readReg(rs1Addr_i);
        rs2Data_o = readReg(rs2Addr_i);
    end

    assign a0_o = regs[10];

    // Writes aimed at x0 must not land in a stored register
    assert property (@(posedge clk) disable iff (!rstN_i)
        (memWb_i.valid && memWb_i.regWrite && memWb_i.rd == 5'd0)
        |=> $stable(a0_o))
        else $error("rvRegFile: write to x0 changed a stored register");

endmodule

`default_nettype wire

// File: fetch/rvFetch.sv
`timescale 1ns/1ps
`default_nettype none

module rvFetch (
    input  wire logic                      clk,
    input  wire logic                      rstN_i,
    input  wire logic                      imemWe_i,
    input  wire logic [rvPkg::IMEM_AW-1:0] imemAddr_i,
    input  wire logic [rvPkg::XLEN-1:0]    imemData_i,
    input  wire logic                      redirectValid_i,
    input  wire logic [rvPkg::XLEN-1:0]    redirectPc_i,
    output rvPkg::fetchDecT                fetchDec_o
);

    logic [rvPkg::XLEN-1:0] imem [rvPkg::IMEM_WORDS];
    logic [rvPkg::XLEN-1:0] pc;
    logic [rvPkg::XLEN-1:0] instr;

    // Program load port
    always_ff @(posedge clk) begin
        if (imemWe_i) begin
            imem[imemAddr_i] <= imemData_i;
        end
    end

    // Word index from the PC
    assign instr = imem[pc[rvPkg::IMEM_AW+1:2]];

    //////////////////////////////
    // PC and fetch/decode reg
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pc         <= '0;
            fetchDec_o <= '0;
        end else begin
            // Redirect comes from execute, two slots behind
            pc               <= redirectValid_i ? redirectPc_i : pc + 32'd4;
            fetchDec_o.valid <= 1'b1;
            fetchDec_o.pc    <= pc;
            fetchDec_o.instr <= instr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rvControl.sv
`timescale 1ns/1ps
`default_nettype none

module rvControl (
    input  wire logic [rvPkg::XLEN-1:0] instr_i,
    output rvPkg::ctrlT                 ctrl_o
);

    rvPkg::opcodeT opcode;
    logic [2:0]    funct3;
    logic          funct7b5;

    assign opcode   = rvPkg::opcodeT'(instr_i[6:0]);
    assign funct3   = instr_i[14:12];
    assign funct7b5 = instr_i[30];

    // funct3 to ALU operation, SUB only exists in the register form
    function automatic rvPkg::aluOpT aluDecode(input logic [2:0] f3, input logic alt,
                                               input logic isReg);
        rvPkg::aluOpT op;
        case (f3)
            3'b000:  op = (isReg && alt) ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            3'b001:  op = rvPkg::ALU_SLL;
            3'b010:  op = rvPkg::ALU_SLT;
            3'b011:  op = rvPkg::ALU_SLTU;
            3'b100:  op = rvPkg::ALU_XOR;
            3'b101:  op = alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
            3'b110:  op = rvPkg::ALU_OR;
            default: op = rvPkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            rvPkg::OPC_OP: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluOp    = aluDecode(funct3, funct7b5, 1'b1);
            end
            rvPkg::OPC_OP_IMM: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.immSel    = rvPkg::IMM_I;
                ctrl_o.aluOp     = aluDecode(funct3, funct7b5, 1'b0);
            end
            rvPkg::OPC_LOAD: begin
                // Word loads only
                if (funct3 == 3'b010) begin
                    ctrl_o.regWrite  = 1'b1;
                    ctrl_o.memRead   = 1'b1;
                    ctrl_o.aluSrcImm = 1'b1;
                    ctrl_o.immSel    = rvPkg::IMM_I;
                    ctrl_o.wbSel     = rvPkg::WB_MEM;
                end
            end
            rvPkg::OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    ctrl_o.memWrite  = 1'b1;
                    ctrl_o.aluSrcImm = 1'b1;
                    ctrl_o.immSel    = rvPkg::IMM_S;
                end
            end
            rvPkg::OPC_BRANCH: begin
                // BEQ, BNE, BLT, BGE
                if (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101}) begin
                    ctrl_o.branch = 1'b1;
                    ctrl_o.immSel = rvPkg::IMM_B;
                end
            end
            rvPkg::OPC_JAL: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.jal      = 1'b1;
                ctrl_o.immSel   = rvPkg::IMM_J;
                ctrl_o.wbSel    = rvPkg::WB_PC4;
            end
            rvPkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl_o.regWrite  = 1'b1;
                    ctrl_o.jalr      = 1'b1;
                    ctrl_o.aluSrcImm = 1'b1;
                    ctrl_o.immSel    = rvPkg::IMM_I;
                    ctrl_o.wbSel     = rvPkg::WB_PC4;
                end
            end
            rvPkg::OPC_LUI: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.immSel    = rvPkg::IMM_U;
                ctrl_o.aluOp     = rvPkg::ALU_PASS_B;
            end
            rvPkg::OPC_AUIPC: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcPc  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.immSel    = rvPkg::IMM_U;
            end
            default: ctrl_o = '0;
        endcase
    end

    // Every known instruction must give a fully known control word
    always_comb begin
        if (!$isunknown(instr_i)) begin
            assert (!$isunknown(ctrl_o))
                else $error("rvControl: unknown control for instr %h", instr_i);
        end
    end

endmodule

`default_nettype wire

// File: common/rvPkg.sv
`default_nettype none

package rvPkg;

    // Datapath and memory sizes
    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = 8;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B
    } aluOpT;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immSelT;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSelT;

    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        logic   memRead;
        logic   branch;
        logic   jal;
        logic   jalr;
        logic   aluSrcImm;
        logic   aluSrcPc;
        aluOpT  aluOp;
        immSelT immSel;
        wbSelT  wbSel;
    } ctrlT;

    //////////////////////////////
    // Stage registers
    //////////////////////////////

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetchDecT;

    typedef struct packed {
        logic            valid;
        ctrlT            ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1Data;
        logic [XLEN-1:0] rs2Data;
        logic [XLEN-1:0] imm;
        logic [2:0]      funct3;
        logic [4:0]      rd;
    } decExeT;

    typedef struct packed {
        logic            valid;
        logic            regWrite;
        logic            memWrite;
        logic            memRead;
        wbSelT           wbSel;
        logic [XLEN-1:0] aluResult;
        logic [XLEN-1:0] storeData;
        logic [XLEN-1:0] pcPlus4;
        logic [4:0]      rd;
    } exeMemT;

    typedef struct packed {
        logic            valid;
        logic            regWrite;
        logic [4:0]      rd;
        logic [XLEN-1:0] wbData;
    } memWbT;

endpackage

`default_nettype wire
